// ==== hdl/icache_pkg.sv ====
package icache_pkg;

	// fetch and memory byte address width
	localparam int ADDR_W = 32;

	// instruction and burst beat width
	localparam int WORD_W = 32;

	// associativity
	localparam int NUM_WAYS = 4;

	// beats per line, one instruction per beat
	localparam int WORDS_PER_LINE = 4;

	// byte offset inside a line, 16 bytes per line
	localparam int OFFSET_W = 4;

	// lowest address bit of the word select
	localparam int WORD_LSB = 2;

	// byte address
	typedef logic [ADDR_W-1:0] addr_t;

	// one instruction or one memory beat
	typedef logic [WORD_W-1:0] word_t;

	// one bit per way, one-hot or zero
	typedef logic [NUM_WAYS-1:0] way_mask_t;

	// word within a line, address bits 3..2
	typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

	// index starts right above the line offset;
	// the tag takes what is left above the index,
	// each module derives that width from SET_BITS

endpackage

// ==== hdl/icache_refill_if.sv ====
`timescale 1ns/10ps

interface icache_refill_if import icache_pkg::*; #(
	parameter int SET_BITS = 6
) ();

	localparam int TAG_W = ADDR_W - OFFSET_W - SET_BITS;

	// one refill beat goes into the arrays this cycle
	logic wr_en;
	// victim way, one-hot
	way_mask_t way;
	// set of the line being filled
	logic [SET_BITS-1:0] index;
	// word slot for this beat
	word_sel_t word;
	word_t wdata;
	// final beat, tag gets installed with it
	logic last;
	// tag of the latched miss line
	logic [TAG_W-1:0] tag;

	modport source (output wr_en, way, index, word, wdata, last, tag);
	modport sink (input wr_en, way, index, word, wdata, last, tag);

endinterface

// ==== hdl/icache_tag_dir.sv ====
`timescale 1ns/10ps

module icache_tag_dir import icache_pkg::*; #(
	parameter int SET_BITS = 6
) (
	input logic clk,
	input logic rst,
	input addr_t addr,
	input logic inv_valid,
	input addr_t inv_addr,
	icache_refill_if.sink refill,
	output way_mask_t hit_way
);

	localparam int SETS = 1 << SET_BITS;
	localparam int TAG_W = ADDR_W - OFFSET_W - SET_BITS;

	// per way tag storage
	logic [TAG_W-1:0] tag_mem [NUM_WAYS][SETS];
	// one valid bit per set in each way
	logic [SETS-1:0] valid_bits [NUM_WAYS];

	// lookup fields of the fetch address
	logic [SET_BITS-1:0] look_index;
	logic [TAG_W-1:0] look_tag;

	// fields of the invalidate address
	logic [SET_BITS-1:0] inv_index;
	logic [TAG_W-1:0] inv_tag;

	// ways the invalidate strobe clears this cycle
	way_mask_t inv_match;

	// tag install strobe on the last beat of a refill
	logic install;

	assign look_index = addr[OFFSET_W +: SET_BITS];
	assign look_tag = addr[ADDR_W-1 -: TAG_W];
	assign inv_index = inv_addr[OFFSET_W +: SET_BITS];
	assign inv_tag = inv_addr[ADDR_W-1 -: TAG_W];
	assign install = refill.wr_en && refill.last;

	// all four ways compared in parallel against the fetch address
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_way[w] = valid_bits[w][look_index] &&
				(tag_mem[w][look_index] == look_tag);
		end
	end

	// a way matches the invalidate if it already holds the line,
	// or if the line is being installed into it in this same cycle
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			inv_match[w] = inv_valid &&
				((tag_mem[w][inv_index] == inv_tag) ||
				(install && refill.way[w] && (refill.index == inv_index) &&
				(refill.tag == inv_tag)));
		end
	end

	// tag install on the final refill beat
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (install && refill.way[w]) begin
				tag_mem[w][refill.index] <= refill.tag;
			end
		end
	end

	// valid bits are set by refill and cleared by snoop
	// the clear comes last so an invalidate beats a same-cycle install
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (install && refill.way[w]) begin
					valid_bits[w][refill.index] <= 1'b1;
				end
				if (inv_match[w]) begin
					valid_bits[w][inv_index] <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== hdl/icache_data_ram.sv ====
`timescale 1ns/10ps

module icache_data_ram import icache_pkg::*; #(
	parameter int SET_BITS = 6
) (
	input logic clk,
	input logic rd_en,
	input logic [SET_BITS-1:0] rd_index,
	icache_refill_if.sink refill,
	output word_t [NUM_WAYS-1:0][WORDS_PER_LINE-1:0] rd_data
);

	localparam int SETS = 1 << SET_BITS;

	// line storage split into word columns,
	// so a single beat can be written without read-modify-write
	word_t mem [NUM_WAYS][WORDS_PER_LINE][SETS];

	// one word per refill beat into the victim way
	always_ff @(posedge clk) begin
		if (refill.wr_en) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (refill.way[w]) begin
					mem[w][refill.word][refill.index] <= refill.wdata;
				end
			end
		end
	end

	// whole set read out, all ways and all words,
	// output holds while no lookup is presented
	always_ff @(posedge clk) begin
		if (rd_en) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int k = 0; k < WORDS_PER_LINE; k++) begin
					rd_data[w][k] <= mem[w][k][rd_index];
				end
			end
		end
	end

endmodule

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl import icache_pkg::*; #(
	parameter int SET_BITS = 6
) (
	input logic clk,
	input logic rst,
	input addr_t addr,
	input logic valid,
	input logic flush,
	input way_mask_t hit_way,
	input word_t [NUM_WAYS-1:0][WORDS_PER_LINE-1:0] rd_data,
	output logic rd_en,
	output logic [SET_BITS-1:0] rd_index,
	icache_refill_if.source refill,
	output addr_t ar_addr,
	output logic ar_valid,
	input logic ar_ready,
	input word_t r_data,
	input logic r_valid,
	input logic r_last,
	output word_t inst,
	output logic ready
);

	localparam int TAG_W = ADDR_W - OFFSET_W - SET_BITS;

	typedef enum logic {
		ST_IDLE,
		ST_REFILL
	} state_t;

	state_t state;

	// lookup outcome in idle
	logic is_idle;
	logic lookup_hit;
	logic lookup_miss;

	// line address of the miss, latched when the burst is accepted
	addr_t line_addr_q;

	// beat position inside the burst
	word_sel_t beat_q;

	// round-robin victim, one-hot
	way_mask_t victim_q;

	// hit state carried into the output cycle
	way_mask_t hit_way_q;
	word_sel_t word_q;
	logic ready_q;

	assign is_idle = (state == ST_IDLE);
	assign lookup_hit = is_idle && valid && (hit_way != '0);
	assign lookup_miss = is_idle && valid && (hit_way == '0);

	// data array is read alongside the tag compare
	assign rd_en = is_idle && valid;
	assign rd_index = addr[OFFSET_W +: SET_BITS];

	// burst request straight from the fetch address, line aligned
	assign ar_valid = lookup_miss;
	assign ar_addr = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

	// refill write bundle, every beat is taken
	assign refill.wr_en = (state == ST_REFILL) && r_valid;
	assign refill.way = victim_q;
	assign refill.index = line_addr_q[OFFSET_W +: SET_BITS];
	assign refill.word = beat_q;
	assign refill.wdata = r_data;
	assign refill.last = r_last;
	assign refill.tag = line_addr_q[ADDR_W-1 -: TAG_W];

	// idle / refill sequencing, victim and beat counter
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			beat_q <= '0;
			victim_q <= way_mask_t'(1);
		end else begin
			case (state)
				ST_IDLE: begin
					if (lookup_miss && ar_ready) begin
						state <= ST_REFILL;
						beat_q <= '0;
					end
				end
				ST_REFILL: begin
					if (r_valid) begin
						beat_q <= beat_q + 1'b1;
						if (r_last) begin
							state <= ST_IDLE;
							// next refill goes to the following way
							victim_q <= {victim_q[NUM_WAYS-2:0], victim_q[NUM_WAYS-1]};
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// miss line captured on request acceptance
	always_ff @(posedge clk) begin
		if (lookup_miss && ar_ready) begin
			line_addr_q <= ar_addr;
		end
	end

	// hit way and word for the output mux
	always_ff @(posedge clk) begin
		if (lookup_hit) begin
			hit_way_q <= hit_way;
			word_q <= addr[WORD_LSB +: $bits(word_sel_t)];
		end
	end

	// ready pulse one cycle after a hit, a flush drops it
	always_ff @(posedge clk) begin
		if (rst) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= lookup_hit && !flush;
		end
	end

	assign ready = ready_q;

	// pick the hit way, then the word, from the registered set
	always_comb begin
		inst = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (hit_way_q[w]) begin
				inst = inst | rd_data[w][word_q];
			end
		end
	end

endmodule

// ==== hdl/icache_top.sv ====
`timescale 1ns/10ps

module icache_top import icache_pkg::*; #(
	parameter int SET_BITS = 6
) (
	input logic clk,
	input logic rst,
	// core fetch side
	input addr_t addr,
	input logic valid,
	input logic flush,
	input logic inv_valid,
	input addr_t inv_addr,
	output word_t inst,
	output logic ready,
	// burst read request
	output addr_t ar_addr,
	output logic ar_valid,
	input logic ar_ready,
	// burst read response, always accepted
	input word_t r_data,
	input logic r_valid,
	input logic r_last
);

	// tag compare result for the current fetch address
	way_mask_t hit_way;

	// data array read port
	logic rd_en;
	logic [SET_BITS-1:0] rd_index;
	word_t [NUM_WAYS-1:0][WORDS_PER_LINE-1:0] rd_data;

	// refill writes shared by tags and data
	icache_refill_if #(.SET_BITS(SET_BITS)) refill_bus ();

	icache_tag_dir #(.SET_BITS(SET_BITS)) u_tag_dir (
		.clk (clk),
		.rst (rst),
		.addr (addr),
		.inv_valid (inv_valid),
		.inv_addr (inv_addr),
		.refill (refill_bus.sink),
		.hit_way (hit_way)
	);

	icache_data_ram #(.SET_BITS(SET_BITS)) u_data_ram (
		.clk (clk),
		.rd_en (rd_en),
		.rd_index (rd_index),
		.refill (refill_bus.sink),
		.rd_data (rd_data)
	);

	icache_ctrl #(.SET_BITS(SET_BITS)) u_ctrl (
		.clk (clk),
		.rst (rst),
		.addr (addr),
		.valid (valid),
		.flush (flush),
		.hit_way (hit_way),
		.rd_data (rd_data),
		.rd_en (rd_en),
		.rd_index (rd_index),
		.refill (refill_bus.source),
		.ar_addr (ar_addr),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r_data (r_data),
		.r_valid (r_valid),
		.r_last (r_last),
		.inst (inst),
		.ready (ready)
	);

endmodule

// ==== tests/tb_mem_model.sv ====
`timescale 1ns/10ps

module tb_mem_model (
	input logic clk,
	input logic rst,
	// mask applied to every random stall length
	input logic [3:0] stall_mask,
	input logic [31:0] ar_addr,
	input logic ar_valid,
	output logic ar_ready,
	output logic [31:0] r_data,
	output logic r_valid,
	output logic r_last
);

	logic [31:0] rnd_state;
	logic [31:0] line_addr;
	logic [31:0] beat_addr;
	logic [3:0] gap;

	// xorshift32 step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// all outputs change on the falling edge only
	initial begin
		rnd_state = 32'h95fc_1fd6;
		ar_ready = 1'b0;
		r_data = '0;
		r_valid = 1'b0;
		r_last = 1'b0;
		forever begin
			// wait for a request seen at a rising edge
			@(posedge clk);
			while (rst || !ar_valid) begin
				@(posedge clk);
			end
			// request stall, ar_ready held low
			rnd_state = xorshift32(rnd_state);
			gap = rnd_state[3:0] & stall_mask;
			repeat (gap) @(negedge clk);
			@(negedge clk);
			ar_ready = 1'b1;
			// accepted at this edge
			@(posedge clk);
			line_addr = ar_addr;
			@(negedge clk);
			ar_ready = 1'b0;
			for (int beat = 0; beat < 4; beat++) begin
				// idle cycles in front of each beat
				rnd_state = xorshift32(rnd_state);
				gap = rnd_state[7:4] & stall_mask;
				repeat (gap) begin
					r_valid = 1'b0;
					r_last = 1'b0;
					@(negedge clk);
				end
				// data is the byte address xor a fixed pattern
				beat_addr = line_addr + 32'(beat * 4);
				r_data = beat_addr ^ 32'hA5A5_0000;
				r_valid = 1'b1;
				r_last = (beat == 3);
				@(negedge clk);
			end
			r_valid = 1'b0;
			r_last = 1'b0;
		end
	end

endmodule

// ==== tests/tb_icache.sv ====
`timescale 1ns/10ps

module tb_icache import icache_pkg::*; ();

	localparam int FETCH_TIMEOUT = 300;

	logic clk;
	logic rst;
	addr_t addr;
	logic valid;
	logic flush;
	logic inv_valid;
	addr_t inv_addr;
	word_t inst;
	logic ready;
	addr_t ar_addr;
	logic ar_valid;
	logic ar_ready;
	word_t r_data;
	logic r_valid;
	logic r_last;
	logic [3:0] stall_mask;

	// bookkeeping from the bus monitor
	int burst_count = 0;
	int hold_errors = 0;
	addr_t last_ar_addr;
	logic req_pending;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	icache_top #(.SET_BITS(6)) u_dut (
		.clk (clk),
		.rst (rst),
		.addr (addr),
		.valid (valid),
		.flush (flush),
		.inv_valid (inv_valid),
		.inv_addr (inv_addr),
		.inst (inst),
		.ready (ready),
		.ar_addr (ar_addr),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r_data (r_data),
		.r_valid (r_valid),
		.r_last (r_last)
	);

	tb_mem_model u_mem (
		.clk (clk),
		.rst (rst),
		.stall_mask (stall_mask),
		.ar_addr (ar_addr),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r_data (r_data),
		.r_valid (r_valid),
		.r_last (r_last)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// counts accepted bursts and checks that a request holds until accepted
	always @(posedge clk) begin
		if (rst) begin
			req_pending <= 1'b0;
		end else begin
			if (req_pending && !ar_valid) begin
				$display("ar_valid dropped before its request was accepted");
				hold_errors <= hold_errors + 1;
			end
			if (ar_valid && ar_ready) begin
				burst_count <= burst_count + 1;
				last_ar_addr <= ar_addr;
			end
			req_pending <= ar_valid && !ar_ready;
		end
	end

	// memory word for any byte address inside a word
	function automatic word_t expected_word(input addr_t a);
		return {a[31:2], 2'b00} ^ 32'hA5A5_0000;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// holds valid until ready and is called on a falling edge
	task automatic fetch(input addr_t a, output word_t data, output int bursts);
		int start_count;
		int cycles;
		logic got;
		start_count = burst_count;
		cycles = 0;
		got = 1'b0;
		addr = a;
		valid = 1'b1;
		while (!got && cycles < FETCH_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			got = ready;
		end
		valid = 1'b0;
		data = inst;
		bursts = burst_count - start_count;
		if (!got) begin
			$display("fetch of %h got no ready within %0d cycles", a, FETCH_TIMEOUT);
			errors++;
		end
	endtask

	task automatic fetch_and_check(input addr_t a, input int exp_bursts);
		word_t data;
		int bursts;
		fetch(a, data, bursts);
		check_value("inst", data, expected_word(a));
		check_value("burst count", bursts, exp_bursts);
	endtask

	task automatic finish_test(input string name, input int err_before);
		int err_now;
		err_now = errors + hold_errors - err_before;
		tests_run++;
		if (err_now == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, err_now);
			tests_failed++;
		end
	endtask

	// line at 0x1000 lives in set 0
	// the first fetch lands mid-line so the burst address must be aligned
	task automatic test_cold_miss();
		int err_before;
		err_before = errors + hold_errors;
		fetch_and_check(32'h0000_1008, 1);
		check_value("ar_addr", last_ar_addr, 32'h0000_1000);
		for (int k = 0; k < 4; k++) begin
			fetch_and_check(32'h0000_1000 + 32'(4 * k), 0);
		end
		finish_test("cold miss then hits", err_before);
	endtask

	// one new address per cycle with ready exactly one cycle later
	task automatic test_back_to_back();
		int err_before;
		int start_count;
		err_before = errors + hold_errors;
		start_count = burst_count;
		addr = 32'h0000_100c;
		valid = 1'b1;
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			check_value("ready", ready, 1);
			check_value("inst", inst, expected_word(32'h0000_100c - 32'(4 * k)));
			if (k < 3) begin
				addr = 32'h0000_100c - 32'(4 * (k + 1));
			end else begin
				valid = 1'b0;
			end
		end
		// ready is a single pulse per request
		@(negedge clk);
		check_value("ready", ready, 0);
		check_value("burst count", burst_count - start_count, 0);
		finish_test("back-to-back hits", err_before);
	endtask

	// five lines in set 5 where the fifth refill lands on the first line's way
	task automatic test_replacement();
		int err_before;
		err_before = errors + hold_errors;
		for (int k = 0; k < 5; k++) begin
			fetch_and_check(32'h0004_0050 + 32'h400 * k, 1);
		end
		// lines two to five still resident
		for (int k = 1; k < 5; k++) begin
			fetch_and_check(32'h0004_0054 + 32'h400 * k, 0);
		end
		fetch_and_check(32'h0004_0058, 1);
		finish_test("replacement order", err_before);
	endtask

	// two lines in set 9 of which only the first is snooped out
	task automatic test_invalidate();
		int err_before;
		err_before = errors + hold_errors;
		fetch_and_check(32'h0008_0090, 1);
		fetch_and_check(32'h0008_0490, 1);
		inv_valid = 1'b1;
		inv_addr = 32'h0008_0098;
		@(negedge clk);
		inv_valid = 1'b0;
		fetch_and_check(32'h0008_0094, 1);
		fetch_and_check(32'h0008_0494, 0);
		finish_test("invalidate", err_before);
	endtask

	task automatic test_flush();
		int err_before;
		err_before = errors + hold_errors;
		addr = 32'h0000_1004;
		valid = 1'b1;
		flush = 1'b1;
		@(negedge clk);
		valid = 1'b0;
		flush = 1'b0;
		check_value("ready", ready, 0);
		fetch_and_check(32'h0000_1004, 0);
		finish_test("flush", err_before);
	endtask

	// four fresh lines under long request and beat stalls
	task automatic test_stalled_memory();
		int err_before;
		err_before = errors + hold_errors;
		stall_mask = 4'hf;
		for (int k = 0; k < 4; k++) begin
			fetch_and_check(32'h0020_0300 + 32'h10 * k + 32'(4 * k), 1);
			for (int j = 0; j < 4; j++) begin
				fetch_and_check(32'h0020_0300 + 32'h10 * k + 32'(4 * j), 0);
			end
		end
		stall_mask = 4'h3;
		finish_test("stalled memory", err_before);
	endtask

	initial begin
		rst = 1'b1;
		addr = '0;
		valid = 1'b0;
		flush = 1'b0;
		inv_valid = 1'b0;
		inv_addr = '0;
		stall_mask = 4'h3;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_cold_miss();
		test_back_to_back();
		test_replacement();
		test_invalidate();
		test_flush();
		test_stalled_memory();
		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, errors + hold_errors);
		if (tests_failed == 0 && errors + hold_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
hdl/icache_pkg.sv
hdl/icache_refill_if.sv
hdl/icache_tag_dir.sv
hdl/icache_data_ram.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
tests/tb_mem_model.sv
tests/tb_icache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_icache -f files.f -o tb_icache \
	|| { echo "build failed"; exit 1; }
./obj_dir/tb_icache | tee /dev/stderr | grep -q "TB PASSED" \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation did not pass"; exit 1; }
